// File: hdl/quarkPkg.sv
package quarkPkg;

   // Data or address word
   typedef logic [31:0] wordT;

   // Register index into the 32-entry file
   typedef logic [4:0] regAddrT;

   // One bit per byte lane of a word
   typedef logic [3:0] byteMaskT;

   // Latched instruction
   // Bits 1:0 are always 2'b11 in RV32I and are not stored
   typedef logic [31:2] instrT;

   // Function field of the instruction
   typedef logic [2:0] funct3T;

   // Core sequencing states, one bit each
   typedef enum logic [3:0] {
      fetchInstr   = 4'b0001,
      waitInstr    = 4'b0010,
      execute      = 4'b0100,
      waitAluOrMem = 4'b1000
   } coreStateT;

   // Opcode field values, instr[6:2]
   // rd <- mem[rs1 + iImm]
   localparam logic [4:0] OpLoad   = 5'b00000;
   // rd <- rs1 op iImm
   localparam logic [4:0] OpAluImm = 5'b00100;
   // rd <- pc + uImm
   localparam logic [4:0] OpAuipc  = 5'b00101;
   // mem[rs1 + sImm] <- rs2
   localparam logic [4:0] OpStore  = 5'b01000;
   // rd <- rs1 op rs2
   localparam logic [4:0] OpAluReg = 5'b01100;
   // rd <- uImm
   localparam logic [4:0] OpLui    = 5'b01101;
   // Conditional pc <- pc + bImm
   localparam logic [4:0] OpBranch = 5'b11000;
   // rd <- pc + 4, pc <- rs1 + iImm
   localparam logic [4:0] OpJalr   = 5'b11001;
   // rd <- pc + 4, pc <- pc + jImm
   localparam logic [4:0] OpJal    = 5'b11011;

   // First instruction fetch address
   localparam wordT ResetAddr = 32'h08000000;

endpackage

// File: hdl/quarkControl.sv
`timescale 1ns/10ps

module quarkControl (
   input  logic            clk,
   input  logic            resetn,
   input  quarkPkg::wordT  memRdata,
   input  logic            memRbusy,
   input  logic            memWbusy,
   input  logic            isLoad,
   input  logic            isStore,
   input  logic            isBranch,
   input  logic            isJal,
   input  logic            isJalr,
   input  quarkPkg::wordT  aluSum,
   input  logic            predicate,
   output quarkPkg::instrT instr,
   output quarkPkg::wordT  pc,
   output quarkPkg::wordT  memAddr,
   output logic            memRstrb,
   output logic            memWstrb,
   output logic            regReadEn,
   output logic            writeBack,
   output logic            memPhase
);
   import quarkPkg::*;

   coreStateT state;

   // State flags
   logic inFetch;
   logic inWaitInstr;
   logic inExecute;
   logic inWaitMem;

   // Next pc path
   wordT pcPlus4;
   wordT pcTarget;
   wordT pcNext;
   logic jump;

   // Loads and stores must wait for the memory before the next fetch
   logic needToWait;

   assign inFetch     = (state == fetchInstr);
   assign inWaitInstr = (state == waitInstr);
   assign inExecute   = (state == execute);
   assign inWaitMem   = (state == waitAluOrMem);

   assign pcPlus4  = pc + 32'd4;
   // Jump and branch targets come from the shared adder, bit 0 cleared for JALR
   assign pcTarget = {aluSum[31:1], 1'b0};
   assign jump     = isJal | isJalr | (isBranch & predicate);
   assign pcNext   = jump ? pcTarget : pcPlus4;

   assign needToWait = isLoad | isStore;

   // Fetch address during fetch and wait
   // Next pc in execute of a non-memory instruction, which overlaps the fetch
   // Otherwise the load/store address from the adder
   assign memAddr = (inFetch | inWaitInstr)           ? pc     :
                    (inExecute & ~isLoad & ~isStore)  ? pcNext :
                                                        aluSum;

   // Execute of anything but a store starts a read
   // either the load itself or the next instruction fetch
   assign memRstrb = inFetch | (inExecute & ~isStore);
   assign memWstrb = inExecute & isStore;

   // Register reads follow the fetched word as it arrives
   assign regReadEn = inWaitInstr & ~memRbusy;

   // Mask is only narrowed while a data access is in flight
   assign memPhase = inExecute | inWaitMem;

   // Non-loads write in execute
   // Loads keep writing in waitAluOrMem, the last write holds the final data
   assign writeBack = ~(isBranch | isStore) &
                      ((inExecute & ~isLoad) | (inWaitMem & isLoad));

   always_ff @(posedge clk) begin
      if (!resetn) begin
         // Wait for both busy inputs before the first fetch
         state <= waitAluOrMem;
         pc    <= ResetAddr;
         // Opcode field 5'b00001 matches no class, rd is x0
         instr <= 30'd1;
      end else begin
         unique case (state)
            waitInstr: begin
               if (!memRbusy) begin
                  instr <= memRdata[31:2];
                  state <= execute;
               end
            end
            execute: begin
               pc    <= pcNext;
               state <= needToWait ? waitAluOrMem : waitInstr;
            end
            waitAluOrMem: begin
               if (!memRbusy && !memWbusy) begin
                  state <= fetchInstr;
               end
            end
            default: begin
               // fetchInstr lasts one cycle
               state <= waitInstr;
            end
         endcase
      end
   end

endmodule

// File: hdl/quarkDecoder.sv
`timescale 1ns/10ps

module quarkDecoder (
   input  quarkPkg::instrT   instr,
   output quarkPkg::regAddrT rdId,
   output logic [7:0]        funct3Is,
   output logic              isLoad,
   output logic              isAluImm,
   output logic              isAuipc,
   output logic              isStore,
   output logic              isAluReg,
   output logic              isLui,
   output logic              isBranch,
   output logic              isJalr,
   output logic              isJal,
   output quarkPkg::wordT    uImm,
   output quarkPkg::wordT    iImm,
   output quarkPkg::wordT    sImm,
   output quarkPkg::wordT    bImm,
   output quarkPkg::wordT    jImm,
   output logic              subSel,
   output logic              arithShift
);
   import quarkPkg::*;

   logic [4:0] opcode;
   funct3T     funct3;

   assign opcode = instr[6:2];
   assign funct3 = instr[14:12];
   assign rdId   = instr[11:7];

   // One-hot function, funct3Is[n] set when funct3 == n
   assign funct3Is = 8'b00000001 << funct3;

   // Instruction classes
   assign isLoad   = (opcode == OpLoad);
   assign isAluImm = (opcode == OpAluImm);
   assign isAuipc  = (opcode == OpAuipc);
   assign isStore  = (opcode == OpStore);
   assign isAluReg = (opcode == OpAluReg);
   assign isLui    = (opcode == OpLui);
   assign isBranch = (opcode == OpBranch);
   assign isJalr   = (opcode == OpJalr);
   assign isJal    = (opcode == OpJal);

   // The five immediate formats, all sign extended from bit 31
   assign uImm = {instr[31:12], 12'b0};
   assign iImm = {{21{instr[31]}}, instr[30:20]};
   assign sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   // Bit 30 selects SUB, but ADDI immediates also reach bit 30
   // Bit 5 is set only for the register form
   assign subSel = instr[30] & instr[5];

   // Bit 30 selects SRA over SRL
   assign arithShift = instr[30];

endmodule

// File: hdl/quarkRegFile.sv
`timescale 1ns/10ps

module quarkRegFile (
   input  logic              clk,
   input  quarkPkg::regAddrT readAddr1,
   input  quarkPkg::regAddrT readAddr2,
   input  logic              readEn,
   input  logic              writeEn,
   input  quarkPkg::regAddrT writeAddr,
   input  quarkPkg::wordT    writeData,
   output quarkPkg::wordT    rs1Data,
   output quarkPkg::wordT    rs2Data
);
   import quarkPkg::*;

   wordT regs [32];

   // All registers start at zero, x0 then stays zero
   initial begin
      for (int i = 0; i < 32; i++) begin
         regs[i] = '0;
      end
   end

   // Single write port, x0 never written
   always_ff @(posedge clk) begin
      if (writeEn && (writeAddr != 5'd0)) begin
         regs[writeAddr] <= writeData;
      end
   end

   // Operands captured as the instruction word arrives
   always_ff @(posedge clk) begin
      if (readEn) begin
         rs1Data <= regs[readAddr1];
         rs2Data <= regs[readAddr2];
      end
   end

endmodule

// File: hdl/quarkAlu.sv
`timescale 1ns/10ps

module quarkAlu (
   input  quarkPkg::wordT rs1Data,
   input  quarkPkg::wordT rs2Data,
   input  quarkPkg::wordT pc,
   input  logic           isAluImm,
   input  logic           isAluReg,
   input  logic           isLoad,
   input  logic           isStore,
   input  logic           isJalr,
   input  logic           isJal,
   input  logic           isAuipc,
   input  logic           isBranch,
   input  logic [7:0]     funct3Is,
   input  quarkPkg::wordT iImm,
   input  quarkPkg::wordT sImm,
   input  quarkPkg::wordT bImm,
   input  quarkPkg::wordT jImm,
   input  quarkPkg::wordT uImm,
   input  logic           subSel,
   input  logic           arithShift,
   output quarkPkg::wordT aluSum,
   output quarkPkg::wordT aluOut,
   output logic           predicate
);
   import quarkPkg::*;

   // Mirror a word so a right shifter can also shift left
   function automatic wordT reverseBits(input wordT value);
      wordT result;
      for (int i = 0; i < 32; i++) begin
         result[i] = value[31 - i];
      end
      return result;
   endfunction

   wordT aluIn1;
   wordT aluIn2;
   wordT plusIn1;
   wordT plusIn2;

   // Subtract and compare
   logic [32:0] aluMinus;
   logic        lt;
   logic        ltu;
   logic        eq;

   // Shifter
   wordT              shifterIn;
   logic signed [32:0] shiftIn;
   logic signed [32:0] shiftOut;
   wordT              shifter;
   wordT              leftShift;

   assign aluIn1 = rs1Data;
   // rs2 for register ops and branches, immediate otherwise
   assign aluIn2 = (isAluReg | isBranch) ? rs2Data : iImm;

   // Shared adder, ALU add as well as load/store address and jump target
   assign plusIn1 = (isAluImm | isAluReg | isLoad | isStore | isJalr) ? rs1Data : pc;
   assign plusIn2 = isStore  ? sImm    :
                    isJal    ? jImm    :
                    isAuipc  ? uImm    :
                    isBranch ? bImm    :
                    isAluReg ? rs2Data :
                               iImm;
   assign aluSum  = plusIn1 + plusIn2;

   // One 33-bit subtract gives SUB and every comparison
   assign aluMinus = {1'b0, aluIn1} - {1'b0, aluIn2};
   assign ltu      = aluMinus[32];
   // Signs differ, the negative operand is the smaller one
   assign lt       = (aluIn1[31] ^ aluIn2[31]) ? aluIn1[31] : aluMinus[32];
   assign eq       = (aluMinus[31:0] == 32'd0);

   // Left shift is a right shift of the reversed word
   assign shifterIn = funct3Is[1] ? reverseBits(aluIn1) : aluIn1;
   // Extra top bit carries the sign fill for SRA
   assign shiftIn   = {arithShift & aluIn1[31], shifterIn};
   assign shiftOut  = shiftIn >>> aluIn2[4:0];
   assign shifter   = shiftOut[31:0];
   assign leftShift = reverseBits(shifter);

   // Only the selected funct3 term is nonzero
   assign aluOut =
      (funct3Is[0] ? (subSel ? aluMinus[31:0] : aluSum) : 32'd0) |
      (funct3Is[1] ? leftShift                          : 32'd0) |
      (funct3Is[2] ? {31'd0, lt}                        : 32'd0) |
      (funct3Is[3] ? {31'd0, ltu}                       : 32'd0) |
      (funct3Is[4] ? (aluIn1 ^ aluIn2)                  : 32'd0) |
      (funct3Is[5] ? shifter                            : 32'd0) |
      (funct3Is[6] ? (aluIn1 | aluIn2)                  : 32'd0) |
      (funct3Is[7] ? (aluIn1 & aluIn2)                  : 32'd0);

   // BEQ, BNE, BLT, BGE, BLTU, BGEU
   assign predicate = (funct3Is[0] &  eq)  |
                      (funct3Is[1] & ~eq)  |
                      (funct3Is[4] &  lt)  |
                      (funct3Is[5] & ~lt)  |
                      (funct3Is[6] &  ltu) |
                      (funct3Is[7] & ~ltu);

endmodule

// File: hdl/quarkLoadStore.sv
`timescale 1ns/10ps

module quarkLoadStore (
   input  quarkPkg::instrT    instr,
   input  logic [1:0]         addrLow,
   input  quarkPkg::wordT     memRdata,
   input  quarkPkg::wordT     rs2Data,
   input  logic               isLoad,
   input  logic               isStore,
   input  logic               memPhase,
   output quarkPkg::wordT     loadData,
   output quarkPkg::wordT     memWdata,
   output quarkPkg::byteMaskT memMask
);
   import quarkPkg::*;

   funct3T   funct3;
   logic     byteAccess;
   logic     halfAccess;
   logic     loadSign;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   byteMaskT accessMask;

   // funct3[1:0] gives the size, 00 byte, 01 halfword, 10 word
   assign funct3     = instr[14:12];
   assign byteAccess = (funct3[1:0] == 2'b00);
   assign halfAccess = (funct3[1:0] == 2'b01);

   // Lane select from the low address bits
   assign loadHalf = addrLow[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = addrLow[0] ? loadHalf[15:8] : loadHalf[7:0];

   // funct3[2] set means zero extension (LBU, LHU)
   assign loadSign = ~funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  memRdata;

   // Store data replicated so the right lane holds it for any offset
   assign memWdata[7:0]   = rs2Data[7:0];
   assign memWdata[15:8]  = addrLow[0] ? rs2Data[7:0] : rs2Data[15:8];
   assign memWdata[23:16] = addrLow[1] ? rs2Data[7:0] : rs2Data[23:16];
   assign memWdata[31:24] = addrLow[0] ? rs2Data[7:0]  :
                            addrLow[1] ? rs2Data[15:8] :
                                         rs2Data[31:24];

   // One lane for bytes, two for halfwords, all four for words
   always_comb begin
      if (byteAccess) begin
         accessMask = 4'b0001 << addrLow;
      end else if (halfAccess) begin
         accessMask = addrLow[1] ? 4'b1100 : 4'b0011;
      end else begin
         accessMask = 4'b1111;
      end
   end

   // Full word mask for instruction fetches
   assign memMask = (memPhase & (isLoad | isStore)) ? accessMask : 4'b1111;

endmodule

// File: hdl/quarkCore.sv
`timescale 1ns/10ps

module quarkCore (
   input  logic               clk,
   input  logic               resetn,
   input  quarkPkg::wordT     memRdata,
   input  logic               memRbusy,
   input  logic               memWbusy,
   output quarkPkg::wordT     memAddr,
   output quarkPkg::wordT     memWdata,
   output quarkPkg::byteMaskT memMask,
   output logic               memRstrb,
   output logic               memWstrb
);
   import quarkPkg::*;

   // Control
   instrT instr;
   wordT  pc;
   wordT  pcPlus4;
   logic  regReadEn;
   logic  writeBack;
   logic  memPhase;

   // Decode
   regAddrT    rdId;
   logic [7:0] funct3Is;
   logic       isLoad;
   logic       isAluImm;
   logic       isAuipc;
   logic       isStore;
   logic       isAluReg;
   logic       isLui;
   logic       isBranch;
   logic       isJalr;
   logic       isJal;
   wordT       uImm;
   wordT       iImm;
   wordT       sImm;
   wordT       bImm;
   wordT       jImm;
   logic       subSel;
   logic       arithShift;

   // Datapath
   wordT rs1Data;
   wordT rs2Data;
   wordT aluSum;
   wordT aluOut;
   logic predicate;
   wordT loadData;
   wordT writeBackData;
   logic regWrite;

   // Link address for JAL and JALR
   assign pcPlus4 = pc + 32'd4;

   // At most one class is active, so the terms can be ORed
   assign writeBackData = (isLui              ? uImm     : 32'd0) |
                          (isAluImm | isAluReg ? aluOut   : 32'd0) |
                          (isAuipc            ? aluSum   : 32'd0) |
                          (isJal | isJalr     ? pcPlus4  : 32'd0) |
                          (isLoad             ? loadData : 32'd0);

   // Only register-writing classes reach the register file
   // SYSTEM and unknown opcodes leave rd unchanged
   assign regWrite = writeBack &
                     (isLui | isAluImm | isAluReg | isAuipc | isJal | isJalr | isLoad);

   quarkControl quarkControl_inst (
      .clk(clk), .resetn(resetn), .memRdata(memRdata),
      .memRbusy(memRbusy), .memWbusy(memWbusy),
      .isLoad(isLoad), .isStore(isStore), .isBranch(isBranch),
      .isJal(isJal), .isJalr(isJalr), .aluSum(aluSum), .predicate(predicate),
      .instr(instr), .pc(pc), .memAddr(memAddr),
      .memRstrb(memRstrb), .memWstrb(memWstrb),
      .regReadEn(regReadEn), .writeBack(writeBack), .memPhase(memPhase)
   );

   quarkDecoder quarkDecoder_inst (
      .instr(instr), .rdId(rdId), .funct3Is(funct3Is),
      .isLoad(isLoad), .isAluImm(isAluImm), .isAuipc(isAuipc),
      .isStore(isStore), .isAluReg(isAluReg), .isLui(isLui),
      .isBranch(isBranch), .isJalr(isJalr), .isJal(isJal),
      .uImm(uImm), .iImm(iImm), .sImm(sImm), .bImm(bImm), .jImm(jImm),
      .subSel(subSel), .arithShift(arithShift)
   );

   // Source fields come from the raw word while it is on the bus
   quarkRegFile quarkRegFile_inst (
      .clk(clk), .readAddr1(memRdata[19:15]), .readAddr2(memRdata[24:20]),
      .readEn(regReadEn), .writeEn(regWrite), .writeAddr(rdId),
      .writeData(writeBackData), .rs1Data(rs1Data), .rs2Data(rs2Data)
   );

   quarkAlu quarkAlu_inst (
      .rs1Data(rs1Data), .rs2Data(rs2Data), .pc(pc),
      .isAluImm(isAluImm), .isAluReg(isAluReg), .isLoad(isLoad),
      .isStore(isStore), .isJalr(isJalr), .isJal(isJal),
      .isAuipc(isAuipc), .isBranch(isBranch), .funct3Is(funct3Is),
      .iImm(iImm), .sImm(sImm), .bImm(bImm), .jImm(jImm), .uImm(uImm),
      .subSel(subSel), .arithShift(arithShift),
      .aluSum(aluSum), .aluOut(aluOut), .predicate(predicate)
   );

   quarkLoadStore quarkLoadStore_inst (
      .instr(instr), .addrLow(aluSum[1:0]), .memRdata(memRdata),
      .rs2Data(rs2Data), .isLoad(isLoad), .isStore(isStore),
      .memPhase(memPhase), .loadData(loadData),
      .memWdata(memWdata), .memMask(memMask)
   );

endmodule

// File: tests/quarkCoreTb.sv
`timescale 1ns/10ps

module quarkCoreTb;
   import quarkPkg::*;

   localparam int   MemWords       = 2048;
   localparam int   CyclesPerInstr = 20;
   localparam wordT DataBase       = ResetAddr + 32'h1000;
   // Reference operation kinds
   localparam int KAdd  = 0;
   localparam int KSub  = 1;
   localparam int KSlt  = 2;
   localparam int KSltu = 3;
   localparam int KXor  = 4;
   localparam int KOr   = 5;
   localparam int KAnd  = 6;
   localparam int KSll  = 7;
   localparam int KSrl  = 8;
   localparam int KSra  = 9;

   logic clk = 1'b0;
   logic resetn;
   wordT memRdata;
   logic memRbusy;
   logic memWbusy;
   wordT memAddr;
   wordT memWdata;
   byteMaskT memMask;
   logic memRstrb;
   logic memWstrb;

   wordT mem [MemWords];
   wordT prog [$];
   // Expected and recorded writes
   wordT expAddr [$];
   wordT expData [$];
   byteMaskT expMask [$];
   wordT recAddr [$];
   wordT recData [$];
   byteMaskT recMask [$];

   wordT rngState = 32'hd76e3a42;
   wordT loopAddr;
   wordT rdAddr;
   wordT rdAddrNext;
   int   rCount = 0;
   int   wCount = 0;
   bit   rdPend = 0;
   bit   wrPend = 0;
   bit   busyOn = 0;
   bit   done = 0;
   bit   fetchSeen = 0;
   int   slot;
   int   errCount;
   int   passCount = 0;
   int   failCount = 0;
   longint budget = 64;
   longint cycles = 0;

   quarkCore quarkCore_inst (
      .clk(clk), .resetn(resetn), .memRdata(memRdata), .memRbusy(memRbusy),
      .memWbusy(memWbusy), .memAddr(memAddr), .memWdata(memWdata), .memMask(memMask),
      .memRstrb(memRstrb), .memWstrb(memWstrb)
   );

   always #10 clk = ~clk;

   function automatic wordT lcg();
      rngState = rngState * 32'd1664525 + 32'd1013904223;
      return rngState;
   endfunction

   // Word index of an address, wrapped into the model
   function automatic int memIndex(input wordT addr);
      wordT off;
      off = (addr - ResetAddr) >> 2;
      return int'(off) & (MemWords - 1);
   endfunction

   // RV32I results computed straight from the ISA definitions
   function automatic wordT refAlu(input int kind, input wordT a, input wordT b);
      case (kind)
         KAdd: return a + b;
         KSub: return a - b;
         KSlt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         KSltu: return (a < b) ? 32'd1 : 32'd0;
         KXor: return a ^ b;
         KOr: return a | b;
         KAnd: return a & b;
         KSll: return a << b[4:0];
         KSrl: return a >> b[4:0];
         default: return wordT'($signed(a) >>> b[4:0]);
      endcase
   endfunction

   function automatic bit refBranch(input logic [2:0] f3, input wordT a, input wordT b);
      case (f3)
         3'd0: return a == b;
         3'd1: return a != b;
         3'd4: return $signed(a) < $signed(b);
         3'd5: return $signed(a) >= $signed(b);
         3'd6: return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic logic [2:0] kindF3(input int kind);
      case (kind)
         KAdd, KSub: return 3'd0;
         KSll: return 3'd1;
         KSlt: return 3'd2;
         KSltu: return 3'd3;
         KXor: return 3'd4;
         KSrl, KSra: return 3'd5;
         KOr: return 3'd6;
         default: return 3'd7;
      endcase
   endfunction

   // Instruction encoders
   function automatic wordT encR(input logic [6:0] f7, input regAddrT rs2, input regAddrT rs1,
                                 input logic [2:0] f3, input regAddrT rd);
      return {f7, rs2, rs1, f3, rd, OpAluReg, 2'b11};
   endfunction

   function automatic wordT encI(input logic [11:0] imm, input regAddrT rs1,
                                 input logic [2:0] f3, input regAddrT rd, input logic [4:0] op);
      return {imm, rs1, f3, rd, op, 2'b11};
   endfunction

   function automatic wordT encS(input logic [11:0] imm, input regAddrT rs2, input regAddrT rs1,
                                 input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], OpStore, 2'b11};
   endfunction

   function automatic wordT encB(input logic [12:0] imm, input regAddrT rs2, input regAddrT rs1,
                                 input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OpBranch, 2'b11};
   endfunction

   function automatic wordT encU(input logic [19:0] imm, input regAddrT rd, input logic [4:0] op);
      return {imm, rd, op, 2'b11};
   endfunction

   function automatic wordT encJ(input logic [20:0] imm, input regAddrT rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OpJal, 2'b11};
   endfunction

   // Address of the next instruction to be emitted
   function automatic wordT pcNow();
      return ResetAddr + 32'(prog.size()) * 32'd4;
   endfunction

   // Byte mask widened to a bit mask
   function automatic wordT laneBits(input byteMaskT m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   task automatic emit(input wordT w);
      prog.push_back(w);
   endtask

   task automatic expectWrite(input wordT addr, input wordT data, input byteMaskT m);
      expAddr.push_back(addr);
      expData.push_back(data);
      expMask.push_back(m);
   endtask

   // LUI plus ADDI with the upper part rounded for the signed low part
   task automatic loadConst(input regAddrT rd, input wordT v);
      wordT up;
      up = v + 32'h800;
      emit(encU(up[31:12], rd, OpLui));
      emit(encI(v[11:0], rd, 3'd0, rd, OpAluImm));
   endtask

   // Word store of one result into the next free slot
   task automatic storeResult(input regAddrT rs, input wordT value);
      wordT off;
      off = 32'(slot) * 32'd4;
      emit(encS(off[11:0], rs, 5'd31, 3'd2));
      expectWrite(DataBase + off, value, 4'hf);
      slot++;
   endtask

   task automatic buildAlu();
      wordT a;
      wordT b;
      wordT pcA;
      for (int r = 0; r < 3; r++) begin
         for (int k = KAdd; k <= KAnd; k++) begin
            a = lcg();
            b = lcg();
            loadConst(5'd1, a);
            loadConst(5'd2, b);
            emit(encR((k == KSub) ? 7'h20 : 7'h00, 5'd2, 5'd1, kindF3(k), 5'd3));
            storeResult(5'd3, refAlu(k, a, b));
         end
         // ADDI with a signed 12-bit immediate
         a = lcg();
         b = lcg();
         loadConst(5'd1, a);
         emit(encI(b[11:0], 5'd1, 3'd0, 5'd3, OpAluImm));
         storeResult(5'd3, a + {{20{b[11]}}, b[11:0]});
         emit(encU(b[31:12], 5'd3, OpLui));
         storeResult(5'd3, {b[31:12], 12'd0});
         // AUIPC adds to its own address
         pcA = pcNow();
         emit(encU(a[31:12], 5'd3, OpAuipc));
         storeResult(5'd3, pcA + {a[31:12], 12'd0});
      end
   endtask

   task automatic buildShift();
      wordT a;
      wordT b;
      for (int r = 0; r < 4; r++) begin
         for (int k = KSll; k <= KSra; k++) begin
            a = lcg();
            b = lcg();
            // Negative operand on odd rounds for SRA sign fill
            a[31] = r[0];
            loadConst(5'd1, a);
            loadConst(5'd2, b);
            emit(encR((k == KSra) ? 7'h20 : 7'h00, 5'd2, 5'd1, kindF3(k), 5'd3));
            storeResult(5'd3, refAlu(k, a, b));
         end
      end
   endtask

   task automatic buildBranch();
      logic [2:0] f3s [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      wordT a;
      wordT b;
      wordT p;
      for (int r = 0; r < 3; r++) begin
         foreach (f3s[i]) begin
            a = lcg();
            b = lcg();
            // Round 1 compares equal operands
            // Round 2 puts a just below b both signed and unsigned
            if (r == 1) begin
               b = a;
            end else if (r == 2) begin
               a[31:30] = 2'b00;
               b = a + 32'd1;
            end
            loadConst(5'd1, a);
            loadConst(5'd2, b);
            // Not taken path marks 0x11 and taken path marks 0x22
            emit(encB(13'd12, 5'd2, 5'd1, f3s[i]));
            emit(encI(12'h011, 5'd0, 3'd0, 5'd4, OpAluImm));
            emit(encJ(21'd8, 5'd0));
            emit(encI(12'h022, 5'd0, 3'd0, 5'd4, OpAluImm));
            storeResult(5'd4, refBranch(f3s[i], a, b) ? 32'h22 : 32'h11);
         end
      end
      // JAL over one store
      p = pcNow();
      emit(encJ(21'd8, 5'd5));
      // Skipped store that would show up as an extra write
      emit(encS(12'h7fc, 5'd0, 5'd31, 3'd2));
      storeResult(5'd5, p + 32'd4);
      // JALR over one store, base taken from AUIPC
      p = pcNow();
      emit(encU(20'd0, 5'd6, OpAuipc));
      emit(encI(12'd12, 5'd6, 3'd0, 5'd7, OpJalr));
      emit(encS(12'h7fc, 5'd0, 5'd31, 3'd2));
      storeResult(5'd7, p + 32'd8);
   endtask

   task automatic buildByte();
      wordT w;
      wordT v;
      wordT off;
      wordT merged;
      byteMaskT m;
      bit half;
      int k;
      for (int t = 0; t < 6; t++) begin
         // Bytes at offsets 0 to 3, then halfwords at 0 and 2
         half = (t >= 4);
         k = half ? (t - 4) * 2 : t;
         w = lcg();
         v = lcg();
         off = 32'(slot) * 32'd4;
         // Background word first
         loadConst(5'd1, w);
         storeResult(5'd1, w);
         loadConst(5'd2, v);
         emit(encS(off[11:0] + 12'(k), 5'd2, 5'd31, half ? 3'd1 : 3'd0));
         m = half ? byteMaskT'(4'b0011 << k) : byteMaskT'(4'b0001 << k);
         expectWrite(DataBase + off, (half ? {16'd0, v[15:0]} : {24'd0, v[7:0]}) << (8 * k), m);
         merged = (w & ~laneBits(m)) | ((v << (8 * k)) & laneBits(m));
         // Signed then unsigned read back
         emit(encI(off[11:0] + 12'(k), 5'd31, half ? 3'd1 : 3'd0, 5'd3, OpLoad));
         storeResult(5'd3, half ? wordT'($signed(merged[8 * k +: 16])) :
                                  wordT'($signed(merged[8 * k +: 8])));
         emit(encI(off[11:0] + 12'(k), 5'd31, half ? 3'd5 : 3'd4, 5'd3, OpLoad));
         storeResult(5'd3, half ? {16'd0, merged[8 * k +: 16]} : {24'd0, merged[8 * k +: 8]});
      end
   endtask

   // Memory model samples the strobes mid cycle where they are stable
   always @(negedge clk) begin
      if (!resetn) begin
         fetchSeen = 0;
      end else begin
         // First access after reset must be the fetch at the reset address
         if (!fetchSeen) begin
            if (memWstrb) begin
               $display("write strobe seen before the first fetch after reset");
               errCount++;
            end
            if (memRstrb) begin
               fetchSeen = 1;
               if (memAddr != ResetAddr) begin
                  $display("error memAddr first fetch expected %h got %h", ResetAddr, memAddr);
                  errCount++;
               end
            end
         end
         if (memRstrb) begin
            rdPend = 1;
            rdAddrNext = memAddr;
            if (memAddr == loopAddr) done = 1;
         end
         // Every write is logged and applied lane by lane
         if (memWstrb) begin
            wrPend = 1;
            recAddr.push_back(memAddr);
            recData.push_back(memWdata);
            recMask.push_back(memMask);
            for (int l = 0; l < 4; l++) begin
               if (memMask[l]) mem[memIndex(memAddr)][8 * l +: 8] = memWdata[8 * l +: 8];
            end
         end
      end
   end

   // Busy counters and read data are driven just after the edge
   always @(posedge clk) begin
      wordT r;
      #1;
      if (rdPend) begin
         rdPend = 0;
         rdAddr = rdAddrNext;
         r = lcg();
         rCount = busyOn ? int'(r[31:30]) : 0;
         memRdata = mem[memIndex(rdAddr)];
      end else if (rCount > 0) begin
         rCount--;
      end
      if (wrPend) begin
         wrPend = 0;
         r = lcg();
         wCount = busyOn ? int'(r[31:30]) : 0;
      end else if (wCount > 0) begin
         wCount--;
      end
      memRbusy = (rCount != 0);
      memWbusy = (wCount != 0);
   end

   // Watchdog against the summed cycle budget of all programs
   always @(posedge clk) begin
      cycles++;
      if (cycles > budget) begin
         $display("watchdog expired after %0d cycles, program did not reach its end loop", cycles);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   // Reset, load the program, release and wait for the end loop
   task automatic runProgram();
      budget += longint'(prog.size()) * CyclesPerInstr + 64;
      @(posedge clk);
      #1 resetn = 1'b0;
      repeat (16) @(posedge clk);
      #1;
      for (int i = 0; i < MemWords; i++) begin
         mem[i] = (ResetAddr + 32'(i) * 32'd4) ^ 32'ha5c30f96;
      end
      foreach (prog[i]) mem[i] = prog[i];
      loopAddr = pcNow() - 32'd4;
      recAddr.delete();
      recData.delete();
      recMask.delete();
      done = 0;
      resetn = 1'b1;
      wait (done);
      repeat (2) @(posedge clk);
   endtask

   // Recorded writes against expected ones, data only in the enabled lanes
   task automatic compareWrites();
      wordT lanes;
      if (recAddr.size() != expAddr.size()) begin
         $display("write count mismatch, expected %0d writes but saw %0d",
                  expAddr.size(), recAddr.size());
         errCount++;
      end
      for (int i = 0; i < expAddr.size() && i < recAddr.size(); i++) begin
         lanes = laneBits(expMask[i]);
         if (recAddr[i][31:2] != expAddr[i][31:2]) begin
            $display("error memAddr write %0d expected %h got %h", i, expAddr[i], recAddr[i]);
            errCount++;
         end
         if (recMask[i] != expMask[i]) begin
            $display("error memMask write %0d expected %h got %h", i, expMask[i], recMask[i]);
            errCount++;
         end
         if ((recData[i] & lanes) != (expData[i] & lanes)) begin
            $display("error memWdata write %0d expected %h got %h", i, expData[i] & lanes,
                     recData[i] & lanes);
            errCount++;
         end
      end
   endtask

   task automatic runTest(input int id);
      errCount = 0;
      slot = 0;
      prog.delete();
      expAddr.delete();
      expData.delete();
      expMask.delete();
      // x31 points at the result area
      emit(encU(DataBase[31:12], 5'd31, OpLui));
      case (id)
         2: buildAlu();
         3: buildShift();
         4: buildBranch();
         5: buildByte();
         6: begin
            buildAlu();
            buildShift();
            buildBranch();
            buildByte();
         end
         default: ;
      endcase
      // Self loop marks the end of the program
      emit(encJ(21'd0, 5'd0));
      busyOn = (id == 6);
      runProgram();
      compareWrites();
      if (errCount == 0) passCount++;
      else failCount++;
      $display("test %0d %s, %0d writes expected, %0d errors", id,
               (errCount == 0) ? "passed" : "failed", expAddr.size(), errCount);
   endtask

   initial begin
      resetn = 1'b0;
      memRdata = '0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
      loopAddr = '1;
      for (int t = 1; t <= 6; t++) runTest(t);
      $display("tests passed %0d, failed %0d", passCount, failCount);
      if (failCount == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: quarkCore.f
hdl/quarkPkg.sv
hdl/quarkControl.sv
hdl/quarkDecoder.sv
hdl/quarkRegFile.sv
hdl/quarkAlu.sv
hdl/quarkLoadStore.sv
hdl/quarkCore.sv
tests/quarkCoreTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the quarkCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module quarkCoreTb \
   -Mdir obj_dir -o quarkCoreSim -f quarkCore.f
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/quarkCoreSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
   exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
   echo "Simulation ended without a result line"
   exit 1
fi
exit 0
